// File: common/cache_pkg.sv
package cache_pkg;

  // 2-way, 256 sets, 16-byte lines
  localparam int way_cnt     = 2;
  localparam int set_idx_w   = 8;
  localparam int line_words  = 4;
  localparam int tag_w       = 20;
  localparam int data_addr_w = 10;

  typedef logic [1:0] word_idx_t;
  typedef logic       way_t;

  typedef struct packed {
    logic             valid;
    logic [tag_w-1:0] addr;
  } dcache_tag_t;

  typedef struct packed {
    logic               valid;
    logic [31:0]        addr;
    logic [31:0]        data;
    logic [3:0]         strobe;
    logic [1:0]         size;
    logic               uncached;
    logic [way_cnt-1:0] hit;
  } store_req_t;

  typedef struct packed {
    logic [31:0]                     addr;
    logic                            is_store;
    logic [31:0]                     data;
    logic [3:0]                      strobe;
    dcache_tag_t [way_cnt-1:0]       tags;
  } miss_req_t;

  typedef enum logic {
    op_read_refill,
    op_write_refill
  } miss_op_e;

  typedef struct packed {
    logic [data_addr_w-1:0]  data_waddr;
    logic [way_cnt-1:0][3:0] data_we;
    logic [31:0]             data_wdata;
    logic [set_idx_w-1:0]    tag_waddr;
    logic [way_cnt-1:0]      tag_we;
    dcache_tag_t             tag_wdata;
  } ram_wport_t;

  function automatic logic [set_idx_w-1:0] set_of(input logic [31:0] addr);
    return addr[11:4];
  endfunction

  // set index plus word offset
  function automatic logic [data_addr_w-1:0] word_addr_of(input logic [31:0] addr);
    return addr[11:2];
  endfunction

  function automatic logic [tag_w-1:0] tag_of(input logic [31:0] addr);
    return addr[31:12];
  endfunction

endpackage

// File: common/bus_pkg.sv
package bus_pkg;

  localparam logic [3:0] burst_single = 4'b0000;
  localparam logic [3:0] burst_line   = 4'b0011;
  localparam logic [1:0] size_word    = 2'b10;

  // address phase fields, then write data phase fields
  typedef struct packed {
    logic        valid;
    logic        write;
    logic [3:0]  burst_size;
    logic [1:0]  data_size;
    logic [31:0] addr;
    logic        data_ok;
    logic        data_last;
    logic [3:0]  data_strobe;
    logic [31:0] w_data;
  } cache_bus_req_t;

  typedef struct packed {
    logic        ready;
    logic        data_ok;
    logic        data_last;
    logic [31:0] r_data;
  } cache_bus_resp_t;

endpackage

// File: src/dirty_array.sv
`timescale 1ns/1ps

module dirty_array (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [cache_pkg::set_idx_w-1:0] raddr_i,
  input  logic [cache_pkg::way_cnt-1:0]   we_i,
  input  logic [cache_pkg::set_idx_w-1:0] waddr_i,
  input  logic                          wdata_i,
  output logic [cache_pkg::way_cnt-1:0]   rdata_o
);
  import cache_pkg::*;

  logic [way_cnt-1:0] dirty_q [1 << set_idx_w];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < (1 << set_idx_w); i++) begin
        dirty_q[i] <= '0;
      end
      rdata_o <= '0;
    end else begin
      for (int w = 0; w < way_cnt; w++) begin
        if (we_i[w]) begin
          dirty_q[waddr_i][w] <= wdata_i;
        end
      end
      // old value on a same-set write
      rdata_o <= dirty_q[raddr_i];
    end
  end

endmodule

// File: lsu_wport/refill_op_reg.sv
`timescale 1ns/1ps

module refill_op_reg (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   miss_valid_i,
  input  cache_pkg::miss_req_t   miss_i,
  input  logic                   op_done_i,
  output logic                   miss_ready_o,
  output logic                   op_valid_o,
  output cache_pkg::miss_req_t   op_o,
  output cache_pkg::miss_op_e    op_type_o,
  output cache_pkg::way_t        victim_way_o,
  output cache_pkg::dcache_tag_t victim_tag_o
);
  import cache_pkg::*;

  logic        op_valid_q;
  way_t        rr_ptr_q;
  miss_req_t   op_q;
  miss_op_e    op_type_q;
  way_t        victim_q;
  dcache_tag_t victim_tag_q;
  logic        accept;

  assign accept = miss_valid_i && !op_valid_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      op_valid_q <= 1'b0;
      rr_ptr_q   <= 1'b0;
    end else if (accept) begin
      op_valid_q <= 1'b1;
      rr_ptr_q   <= ~rr_ptr_q;
    end else if (op_done_i) begin
      op_valid_q <= 1'b0;
    end
  end

  // victim tag comes from the set read that caused the miss
  always_ff @(posedge clk) begin
    if (accept) begin
      op_q         <= miss_i;
      op_type_q    <= miss_i.is_store ? op_write_refill : op_read_refill;
      victim_q     <= rr_ptr_q;
      victim_tag_q <= miss_i.tags[rr_ptr_q];
    end
  end

  assign miss_ready_o = !op_valid_q;
  assign op_valid_o   = op_valid_q;
  assign op_o         = op_q;
  assign op_type_o    = op_type_q;
  assign victim_way_o = victim_q;
  assign victim_tag_o = victim_tag_q;

endmodule

// File: lsu_wport/refill_fsm.sv
`timescale 1ns/1ps

module refill_fsm (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                op_valid_i,
  input  cache_pkg::miss_req_t                op_i,
  input  cache_pkg::miss_op_e                 op_type_i,
  input  cache_pkg::way_t                     victim_way_i,
  input  cache_pkg::dcache_tag_t              victim_tag_i,
  input  logic [cache_pkg::way_cnt-1:0]       victim_dirty_i,
  input  logic                                bus_busy_i,
  input  logic [31:0]                         victim_rdata_i,
  input  bus_pkg::cache_bus_resp_t            bus_resp_i,
  output bus_pkg::cache_bus_req_t             refill_req_o,
  output logic [cache_pkg::data_addr_w-1:0]   victim_raddr_o,
  output logic                                beat_we_o,
  output cache_pkg::word_idx_t                beat_word_o,
  output logic                                tag_update_o,
  output logic                                op_done_o
);
  import cache_pkg::*;
  import bus_pkg::*;

  typedef enum logic [2:0] {
    s_idle,
    s_wait_bus,
    s_wb_addr,
    s_wb_data,
    s_refill_addr,
    s_refill_data,
    s_tag_update
  } state_e;

  state_e      state_q;
  state_e      state_d;
  logic [2:0]  rd_cnt_q;
  logic        rd_pend_q;
  word_idx_t   rd_word_q;
  word_idx_t   beat_q;
  logic [31:0] line_buf_q [line_words];
  logic        fill_done;
  logic        victim_dirty;

  // victim line is read while waiting for the bus, dirty or not
  assign fill_done      = (rd_cnt_q == 3'(line_words)) && !rd_pend_q;
  assign victim_dirty   = victim_tag_i.valid && victim_dirty_i[victim_way_i];
  assign victim_raddr_o = {set_of(op_i.addr), rd_cnt_q[1:0]};

  always_comb begin
    state_d = state_q;
    case (state_q)
      s_idle: begin
        if (op_valid_i) begin
          state_d = s_wait_bus;
        end
      end
      s_wait_bus: begin
        if (fill_done && !bus_busy_i) begin
          state_d = victim_dirty ? s_wb_addr : s_refill_addr;
        end
      end
      s_wb_addr: begin
        if (bus_resp_i.ready) begin
          state_d = s_wb_data;
        end
      end
      s_wb_data: begin
        if (bus_resp_i.data_ok && beat_q == 2'd3) begin
          state_d = s_refill_addr;
        end
      end
      s_refill_addr: begin
        if (bus_resp_i.ready) begin
          state_d = s_refill_data;
        end
      end
      s_refill_data: begin
        if (bus_resp_i.data_ok && bus_resp_i.data_last) begin
          state_d = s_tag_update;
        end
      end
      default: begin
        state_d = s_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q   <= s_idle;
      rd_cnt_q  <= '0;
      rd_pend_q <= 1'b0;
      beat_q    <= '0;
    end else begin
      state_q   <= state_d;
      rd_pend_q <= 1'b0;
      if (state_q == s_idle) begin
        rd_cnt_q <= '0;
      end else if (state_q == s_wait_bus && rd_cnt_q != 3'(line_words)) begin
        rd_cnt_q  <= rd_cnt_q + 3'd1;
        rd_pend_q <= 1'b1;
      end
      // one beat counter serves both bursts
      if (state_q != state_d) begin
        beat_q <= '0;
      end else if ((state_q == s_wb_data || state_q == s_refill_data) && bus_resp_i.data_ok) begin
        beat_q <= beat_q + 2'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    rd_word_q <= rd_cnt_q[1:0];
    if (rd_pend_q) begin
      line_buf_q[rd_word_q] <= victim_rdata_i;
    end
  end

  always_comb begin
    refill_req_o             = '0;
    refill_req_o.burst_size  = burst_line;
    refill_req_o.data_size   = size_word;
    refill_req_o.addr        = {tag_of(op_i.addr), set_of(op_i.addr), 4'b0000};
    refill_req_o.data_strobe = 4'hf;
    refill_req_o.w_data      = line_buf_q[beat_q];
    case (state_q)
      s_wb_addr: begin
        refill_req_o.valid = 1'b1;
        refill_req_o.write = 1'b1;
        refill_req_o.addr  = {victim_tag_i.addr, set_of(op_i.addr), 4'b0000};
      end
      s_wb_data: begin
        refill_req_o.data_ok   = 1'b1;
        refill_req_o.data_last = beat_q == 2'd3;
      end
      s_refill_addr: begin
        refill_req_o.valid = 1'b1;
        // store misses pass their byte lanes along with the read
        if (op_type_i == op_write_refill) begin
          refill_req_o.data_strobe = op_i.strobe;
        end
      end
      s_refill_data: begin
        refill_req_o.data_ok = 1'b1;
      end
      default: begin
      end
    endcase
  end

  assign beat_we_o    = (state_q == s_refill_data) && bus_resp_i.data_ok;
  assign beat_word_o  = beat_q;
  assign tag_update_o = state_q == s_tag_update;
  assign op_done_o    = state_q == s_tag_update;

endmodule

// File: lsu_wport/uncached_wbuf.sv
`timescale 1ns/1ps

module uncached_wbuf (
  input  logic                     clk,
  input  logic                     rst_n,
  input  cache_pkg::store_req_t    store_i,
  input  bus_pkg::cache_bus_req_t  refill_req_i,
  input  bus_pkg::cache_bus_resp_t bus_resp_i,
  output logic                     uc_ready_o,
  output logic                     bus_busy_o,
  output bus_pkg::cache_bus_req_t  bus_req_o
);
  import cache_pkg::*;
  import bus_pkg::*;

  localparam int depth = 4;

  typedef enum logic [1:0] {
    s_empty,
    s_addr,
    s_data
  } state_e;

  state_e         state_q;
  state_e         state_d;
  store_req_t     fifo_q [depth];
  store_req_t     head;
  logic [1:0]     wr_ptr_q;
  logic [1:0]     rd_ptr_q;
  logic           empty_q;
  logic           full_q;
  logic           push;
  logic           pop;
  logic           refill_active;
  cache_bus_req_t uc_req;

  assign head          = fifo_q[rd_ptr_q];
  assign push          = store_i.valid && store_i.uncached && !full_q;
  // entry leaves only once its data beat is taken
  assign pop           = (state_q == s_data) && bus_resp_i.data_ok;
  assign refill_active = refill_req_i.valid || refill_req_i.data_ok;
  assign uc_ready_o    = !full_q;
  assign bus_busy_o    = !empty_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      s_empty: begin
        if (!empty_q && !refill_active) begin
          state_d = s_addr;
        end
      end
      s_addr: begin
        if (bus_resp_i.ready) begin
          state_d = s_data;
        end
      end
      default: begin
        if (bus_resp_i.data_ok) begin
          state_d = s_empty;
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q  <= s_empty;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      empty_q  <= 1'b1;
      full_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 2'd1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 2'd1;
      end
      if (push && !pop) begin
        empty_q <= 1'b0;
        full_q  <= (wr_ptr_q + 2'd1) == rd_ptr_q;
      end else if (pop && !push) begin
        full_q  <= 1'b0;
        empty_q <= (rd_ptr_q + 2'd1) == wr_ptr_q;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      fifo_q[wr_ptr_q] <= store_i;
    end
  end

  always_comb begin
    uc_req             = '0;
    uc_req.write       = 1'b1;
    uc_req.burst_size  = burst_single;
    uc_req.data_size   = head.size;
    uc_req.addr        = head.addr;
    uc_req.data_strobe = head.strobe;
    uc_req.w_data      = head.data;
    uc_req.valid       = state_q == s_addr;
    uc_req.data_ok     = state_q == s_data;
    uc_req.data_last   = state_q == s_data;
  end

  // refill traffic only reaches the bus while no entry is in flight
  assign bus_req_o = (state_q == s_empty) ? refill_req_i : uc_req;

endmodule

// File: lsu_wport/ram_write_ctrl.sv
`timescale 1ns/1ps

module ram_write_ctrl (
  input  logic                            miss_busy_i,
  input  cache_pkg::store_req_t           store_i,
  input  cache_pkg::miss_req_t            op_i,
  input  cache_pkg::miss_op_e             op_type_i,
  input  cache_pkg::way_t                 victim_way_i,
  input  logic                            beat_we_i,
  input  cache_pkg::word_idx_t            beat_word_i,
  input  logic                            tag_update_i,
  input  logic [31:0]                     refill_rdata_i,
  output cache_pkg::ram_wport_t           ram_wport_o,
  output logic [cache_pkg::way_cnt-1:0]   dirty_we_o,
  output logic [cache_pkg::set_idx_w-1:0] dirty_waddr_o,
  output logic                            dirty_wdata_o
);
  import cache_pkg::*;

  always_comb begin
    ram_wport_o            = '0;
    ram_wport_o.data_waddr = word_addr_of(store_i.addr);
    ram_wport_o.data_wdata = store_i.data;
    ram_wport_o.tag_waddr  = set_of(op_i.addr);
    ram_wport_o.tag_wdata  = {1'b1, tag_of(op_i.addr)};
    dirty_we_o             = '0;
    dirty_waddr_o          = set_of(store_i.addr);
    dirty_wdata_o          = 1'b1;
    if (!miss_busy_i) begin
      if (store_i.valid && !store_i.uncached) begin
        for (int w = 0; w < way_cnt; w++) begin
          ram_wport_o.data_we[w] = store_i.hit[w] ? store_i.strobe : 4'h0;
        end
        dirty_we_o = store_i.hit;
      end
    end else if (beat_we_i) begin
      ram_wport_o.data_we[victim_way_i] = 4'hf;
      ram_wport_o.data_waddr            = {set_of(op_i.addr), beat_word_i};
      ram_wport_o.data_wdata            = refill_rdata_i;
    end else if (tag_update_i) begin
      ram_wport_o.tag_we[victim_way_i] = 1'b1;
      dirty_we_o[victim_way_i]         = 1'b1;
      dirty_waddr_o                    = set_of(op_i.addr);
      dirty_wdata_o                    = op_type_i == op_write_refill;
      // store miss merges into the fresh line
      if (op_type_i == op_write_refill) begin
        ram_wport_o.data_we[victim_way_i] = op_i.strobe;
        ram_wport_o.data_waddr            = word_addr_of(op_i.addr);
        ram_wport_o.data_wdata            = op_i.data;
      end
    end
  end

endmodule

// File: lsu_wport/lsu_wport.sv
`timescale 1ns/1ps

module lsu_wport (
  input  logic                              clk,
  input  logic                              rst_n,
  input  cache_pkg::store_req_t             store_i,
  input  logic                              miss_valid_i,
  input  cache_pkg::miss_req_t              miss_i,
  input  logic [31:0]                       victim_rdata_i,
  input  bus_pkg::cache_bus_resp_t          bus_resp_i,
  output logic                              uc_ready_o,
  output logic                              miss_ready_o,
  output logic                              op_done_o,
  output cache_pkg::ram_wport_t             ram_wport_o,
  output logic [cache_pkg::data_addr_w-1:0] victim_raddr_o,
  output bus_pkg::cache_bus_req_t           bus_req_o
);
  import cache_pkg::*;
  import bus_pkg::*;

  logic                 op_valid;
  miss_req_t            op;
  miss_op_e             op_type;
  way_t                 victim_way;
  dcache_tag_t          victim_tag;
  logic [way_cnt-1:0]   dirty_rdata;
  logic [way_cnt-1:0]   dirty_we;
  logic [set_idx_w-1:0] dirty_waddr;
  logic                 dirty_wdata;
  cache_bus_req_t       refill_req;
  logic                 bus_busy;
  logic                 beat_we;
  word_idx_t            beat_word;
  logic                 tag_update;

  // dirty read follows the held miss set
  dirty_array u_dirty (
    .clk     (clk),
    .rst_n   (rst_n),
    .raddr_i (op.addr[11:4]),
    .we_i    (dirty_we),
    .waddr_i (dirty_waddr),
    .wdata_i (dirty_wdata),
    .rdata_o (dirty_rdata)
  );

  refill_op_reg u_op_reg (
    .clk          (clk),
    .rst_n        (rst_n),
    .miss_valid_i (miss_valid_i),
    .miss_i       (miss_i),
    .op_done_i    (op_done_o),
    .miss_ready_o (miss_ready_o),
    .op_valid_o   (op_valid),
    .op_o         (op),
    .op_type_o    (op_type),
    .victim_way_o (victim_way),
    .victim_tag_o (victim_tag)
  );

  refill_fsm u_fsm (
    .clk            (clk),
    .rst_n          (rst_n),
    .op_valid_i     (op_valid),
    .op_i           (op),
    .op_type_i      (op_type),
    .victim_way_i   (victim_way),
    .victim_tag_i   (victim_tag),
    .victim_dirty_i (dirty_rdata),
    .bus_busy_i     (bus_busy),
    .victim_rdata_i (victim_rdata_i),
    .bus_resp_i     (bus_resp_i),
    .refill_req_o   (refill_req),
    .victim_raddr_o (victim_raddr_o),
    .beat_we_o      (beat_we),
    .beat_word_o    (beat_word),
    .tag_update_o   (tag_update),
    .op_done_o      (op_done_o)
  );

  uncached_wbuf u_wbuf (
    .clk          (clk),
    .rst_n        (rst_n),
    .store_i      (store_i),
    .refill_req_i (refill_req),
    .bus_resp_i   (bus_resp_i),
    .uc_ready_o   (uc_ready_o),
    .bus_busy_o   (bus_busy),
    .bus_req_o    (bus_req_o)
  );

  ram_write_ctrl u_wctrl (
    .miss_busy_i    (op_valid),
    .store_i        (store_i),
    .op_i           (op),
    .op_type_i      (op_type),
    .victim_way_i   (victim_way),
    .beat_we_i      (beat_we),
    .beat_word_i    (beat_word),
    .tag_update_i   (tag_update),
    .refill_rdata_i (bus_resp_i.r_data),
    .ram_wport_o    (ram_wport_o),
    .dirty_we_o     (dirty_we),
    .dirty_waddr_o  (dirty_waddr),
    .dirty_wdata_o  (dirty_wdata)
  );

endmodule

// File: verif/tb_lsu_wport.sv
`timescale 1ns/1ps

module tb_lsu_wport;
  import cache_pkg::*;
  import bus_pkg::*;

  localparam int n_ops        = 24;
  localparam int worst_cycles = 200;

  typedef struct packed {
    logic        write;
    logic [31:0] addr;
    logic [3:0]  burst;
    logic [1:0]  size;
  } addr_exp_t;

  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  strobe;
    logic [1:0]  size;
    logic        last;
  } wdata_exp_t;

  logic            clk          = 1'b0;
  logic            rst_n        = 1'b0;
  store_req_t      store_req    = '0;
  logic            miss_valid   = 1'b0;
  miss_req_t       miss_req     = '0;
  logic [31:0]     victim_rdata = '0;
  cache_bus_resp_t bus_resp     = '0;
  logic            uc_ready;
  logic            miss_ready;
  logic            op_done;
  ram_wport_t      ram_wport;
  logic [9:0]      victim_raddr;
  cache_bus_req_t  bus_req;

  logic [31:0] rand_state = 32'd38235;
  addr_exp_t   addr_q [$];
  wdata_exp_t  wdata_q [$];
  logic [31:0] dmodel [2][1024];
  logic [31:0] mem [logic [29:0]];
  dcache_tag_t tag_m [2][256];
  logic        dirty_m [2][256];
  way_t        rr_ptr     = 1'b0;
  way_t        cur_victim = 1'b0;
  logic        cur_store  = 1'b0;
  miss_req_t   cur_miss   = '0;
  logic        bus_hold   = 1'b0;
  // bus slave phase is idle (0), write data (1) or read data (2)
  int          phase      = 0;
  logic [31:0] cur_addr   = '0;
  int          beat       = 0;
  int          burst_len  = 1;
  // high in the cycle after the last refill beat
  logic        refill_end = 1'b0;

  lsu_wport u_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .store_i        (store_req),
    .miss_valid_i   (miss_valid),
    .miss_i         (miss_req),
    .victim_rdata_i (victim_rdata),
    .bus_resp_i     (bus_resp),
    .uc_ready_o     (uc_ready),
    .miss_ready_o   (miss_ready),
    .op_done_o      (op_done),
    .ram_wport_o    (ram_wport),
    .victim_raddr_o (victim_raddr),
    .bus_req_o      (bus_req)
  );

  initial begin
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    rand_state ^= rand_state << 13;
    rand_state ^= rand_state >> 17;
    rand_state ^= rand_state << 5;
    return rand_state;
  endfunction

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return addr ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a_c3c3;
  endfunction

  function automatic logic [31:0] mem_read(input logic [31:0] addr);
    if (mem.exists(addr[31:2])) begin
      return mem[addr[31:2]];
    end
    return fill_word(addr);
  endfunction

  function automatic logic [7:0] way_mask(input way_t w, input logic [3:0] s);
    return w ? {s, 4'h0} : {4'h0, s};
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got == exp) else begin
      fail_run($sformatf("error at %0t: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  // data array behind victim_raddr_o with one cycle of read latency
  always @(posedge clk) begin
    if (!rst_n) begin
      for (int w = 0; w < 2; w++) begin
        for (int i = 0; i < 1024; i++) begin
          dmodel[w][i] <= 32'hd000_0000 ^ (w << 20) ^ (i * 32'h0001_0101);
        end
      end
    end else begin
      victim_rdata <= dmodel[cur_victim][victim_raddr];
      for (int w = 0; w < 2; w++) begin
        for (int b = 0; b < 4; b++) begin
          if (ram_wport.data_we[w][b]) begin
            dmodel[w][ram_wport.data_waddr][8*b +: 8] <= ram_wport.data_wdata[8*b +: 8];
          end
        end
      end
    end
  end

  always @(posedge clk) begin
    if (rst_n) begin
      if (store_req.valid && !store_req.uncached && miss_ready) begin
        for (int w = 0; w < 2; w++) begin
          check_value("data_we", 64'(ram_wport.data_we[w]),
                      64'(store_req.hit[w] ? store_req.strobe : 4'h0));
        end
        check_value("data_waddr", 64'(ram_wport.data_waddr), 64'(store_req.addr[11:2]));
        check_value("data_wdata", 64'(ram_wport.data_wdata), 64'(store_req.data));
      end
      // tag update comes right after the last refill beat
      check_value("op_done_o", 64'(op_done), 64'(refill_end));
      if (refill_end) begin
        check_value("tag_we", 64'(ram_wport.tag_we), 64'(cur_victim ? 2'b10 : 2'b01));
        check_value("tag_waddr", 64'(ram_wport.tag_waddr), 64'(cur_miss.addr[11:4]));
        check_value("tag_wdata", 64'(ram_wport.tag_wdata), 64'({1'b1, cur_miss.addr[31:12]}));
        if (cur_store) begin
          check_value("data_we", 64'(ram_wport.data_we), 64'(way_mask(cur_victim, cur_miss.strobe)));
          check_value("data_waddr", 64'(ram_wport.data_waddr), 64'(cur_miss.addr[11:2]));
          check_value("data_wdata", 64'(ram_wport.data_wdata), 64'(cur_miss.data));
        end else begin
          check_value("data_we", 64'(ram_wport.data_we), 64'(0));
        end
      end else begin
        check_value("tag_we", 64'(ram_wport.tag_we), 64'(0));
      end
    end
  end

  // bus slave with random ready and data_ok delays
  always @(posedge clk) begin
    addr_exp_t   exp_a;
    wdata_exp_t  exp_w;
    logic [29:0] widx;
    logic [31:0] word;
    refill_end <= 1'b0;
    if (!rst_n) begin
      bus_resp <= '0;
      phase    <= 0;
    end else if (phase == 0) begin
      if (bus_req.valid && bus_resp.ready) begin
        assert (addr_q.size() > 0) else fail_run("address phase with no transfer expected");
        exp_a = addr_q.pop_front();
        check_value("bus write", 64'(bus_req.write), 64'(exp_a.write));
        check_value("bus addr", 64'(bus_req.addr), 64'(exp_a.addr));
        check_value("bus burst_size", 64'(bus_req.burst_size), 64'(exp_a.burst));
        check_value("bus data_size", 64'(bus_req.data_size), 64'(exp_a.size));
        bus_resp.ready <= 1'b0;
        cur_addr       <= bus_req.addr;
        beat           <= 0;
        burst_len      <= int'(exp_a.burst) + 1;
        phase          <= bus_req.write ? 1 : 2;
      end else if (bus_req.valid && !bus_hold) begin
        bus_resp.ready <= (next_rand() % 3) == 0;
      end
    end else if (phase == 1) begin
      if (bus_req.data_ok && bus_resp.data_ok) begin
        assert (wdata_q.size() > 0) else fail_run("write beat with no data expected");
        exp_w = wdata_q.pop_front();
        check_value("bus w_data", 64'(bus_req.w_data), 64'(exp_w.data));
        check_value("bus data_strobe", 64'(bus_req.data_strobe), 64'(exp_w.strobe));
        check_value("bus data_size", 64'(bus_req.data_size), 64'(exp_w.size));
        check_value("bus data_last", 64'(bus_req.data_last), 64'(exp_w.last));
        widx = cur_addr[31:2] + 30'(beat);
        word = mem_read({widx, 2'b00});
        for (int b = 0; b < 4; b++) begin
          if (bus_req.data_strobe[b]) begin
            word[8*b +: 8] = bus_req.w_data[8*b +: 8];
          end
        end
        mem[widx] = word;
        bus_resp.data_ok <= 1'b0;
        beat             <= beat + 1;
        if (beat + 1 == burst_len) begin
          phase <= 0;
        end
      end else if (bus_req.data_ok && !bus_hold) begin
        bus_resp.data_ok <= (next_rand() % 3) == 0;
      end
    end else begin
      if (bus_resp.data_ok) begin
        check_value("refill data_we", 64'(ram_wport.data_we), 64'(way_mask(cur_victim, 4'hf)));
        check_value("refill data_waddr", 64'(ram_wport.data_waddr),
                    64'({cur_miss.addr[11:4], 2'(beat)}));
        check_value("refill data_wdata", 64'(ram_wport.data_wdata), 64'(bus_resp.r_data));
        bus_resp.data_ok   <= 1'b0;
        bus_resp.data_last <= 1'b0;
        beat               <= beat + 1;
        if (bus_resp.data_last) begin
          phase      <= 0;
          refill_end <= 1'b1;
        end
      end else if ((next_rand() % 3) == 0) begin
        bus_resp.data_ok   <= 1'b1;
        bus_resp.r_data    <= mem_read(cur_addr + 32'(4 * beat));
        bus_resp.data_last <= beat == burst_len - 1;
      end
    end
  end

  task automatic hit_store(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strobe);
    store_req_t s;
    s        = '0;
    s.valid  = 1'b1;
    s.addr   = addr;
    s.data   = data;
    s.strobe = strobe;
    s.size   = size_word;
    for (int w = 0; w < 2; w++) begin
      s.hit[w] = tag_m[w][addr[11:4]].valid && tag_m[w][addr[11:4]].addr == addr[31:12];
    end
    @(posedge clk);
    while (!miss_ready) @(posedge clk);
    store_req <= s;
    @(posedge clk);
    store_req <= '0;
    for (int w = 0; w < 2; w++) begin
      if (s.hit[w]) begin
        dirty_m[w][addr[11:4]] = 1'b1;
      end
    end
  endtask

  task automatic uc_store(input logic [31:0] addr, input logic [31:0] data,
                          input logic [3:0] strobe);
    store_req_t s;
    s          = '0;
    s.valid    = 1'b1;
    s.addr     = addr;
    s.data     = data;
    s.strobe   = strobe;
    s.size     = size_word;
    s.uncached = 1'b1;
    addr_q.push_back('{1'b1, addr, burst_single, size_word});
    wdata_q.push_back('{data, strobe, size_word, 1'b1});
    @(posedge clk);
    while (!uc_ready) @(posedge clk);
    store_req <= s;
    @(posedge clk);
    store_req <= '0;
  endtask

  task automatic do_miss(input logic [31:0] addr, input logic is_store, input logic [31:0] data,
                         input logic [3:0] strobe);
    miss_req_t m;
    logic [7:0] set;
    way_t v;
    set        = addr[11:4];
    v          = rr_ptr;
    m.addr     = addr;
    m.is_store = is_store;
    m.data     = data;
    m.strobe   = strobe;
    m.tags[0]  = tag_m[0][set];
    m.tags[1]  = tag_m[1][set];
    @(posedge clk);
    while (!miss_ready) @(posedge clk);
    if (tag_m[v][set].valid && dirty_m[v][set]) begin
      addr_q.push_back('{1'b1, {tag_m[v][set].addr, set, 4'h0}, burst_line, size_word});
      for (int k = 0; k < 4; k++) begin
        wdata_q.push_back('{dmodel[v][{set, 2'(k)}], 4'hf, size_word, k == 3});
      end
    end
    addr_q.push_back('{1'b0, {addr[31:4], 4'h0}, burst_line, size_word});
    cur_miss   = m;
    cur_victim = v;
    cur_store  = is_store;
    miss_valid <= 1'b1;
    miss_req   <= m;
    @(posedge clk);
    miss_valid <= 1'b0;
    do @(posedge clk); while (!op_done);
    tag_m[v][set]   = {1'b1, addr[31:12]};
    dirty_m[v][set] = is_store;
    rr_ptr          = ~rr_ptr;
  endtask

  initial begin
    #(n_ops * worst_cycles * 20 + 20000);
    fail_run("watchdog expired before the tests finished");
  end

  initial begin
    logic [31:0] r;
    logic [7:0]  set;
    for (int w = 0; w < 2; w++) begin
      for (int s = 0; s < 256; s++) begin
        tag_m[w][s]   = '0;
        dirty_m[w][s] = 1'b0;
      end
    end
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    check_value("bus valid", 64'(bus_req.valid), 64'(0));
    check_value("bus data_ok", 64'(bus_req.data_ok), 64'(0));
    check_value("data_we", 64'(ram_wport.data_we), 64'(0));
    check_value("tag_we", 64'(ram_wport.tag_we), 64'(0));
    check_value("op_done_o", 64'(op_done), 64'(0));
    check_value("uc_ready_o", 64'(uc_ready), 64'(1));
    check_value("miss_ready_o", 64'(miss_ready), 64'(1));

    // clean fill, hit store, second way, then dirty eviction
    do_miss(32'h0001_2348, 1'b0, '0, '0);
    hit_store(32'h0001_2344, next_rand(), 4'((next_rand() % 15) + 1));
    do_miss(32'h0002_2340, 1'b0, '0, '0);
    do_miss(32'h0003_234c, 1'b1, next_rand(), 4'((next_rand() % 15) + 1));

    bus_hold = 1'b1;
    for (int i = 0; i < 4; i++) begin
      uc_store(32'h8000_0000 + 32'(4 * i), next_rand(), 4'((next_rand() % 15) + 1));
    end
    @(posedge clk);
    assert (!uc_ready) else fail_run("uc_ready_o stayed high with four stores buffered");
    bus_hold = 1'b0;

    // refill must queue behind the buffered writes
    uc_store(32'h8000_0100, next_rand(), 4'hf);
    uc_store(32'h8000_0104, next_rand(), 4'h3);
    do_miss(32'h0004_5670, 1'b0, '0, '0);

    for (int n = 0; n < 12; n++) begin
      r   = next_rand();
      set = r[8] ? 8'h34 : 8'h35;
      case (r[1:0])
        2'd0: do_miss({16'h0010, 2'b00, r[5:4], set, 2'(r[3:2]), 2'b00}, 1'b0, '0, '0);
        2'd1: do_miss({16'h0010, 2'b00, r[5:4], set, 2'(r[3:2]), 2'b00}, 1'b1, next_rand(),
                      4'((next_rand() % 15) + 1));
        2'd2: uc_store({16'h8001, r[15:2], 2'b00}, next_rand(), 4'((next_rand() % 15) + 1));
        default: begin
          if (tag_m[0][set].valid) begin
            hit_store({tag_m[0][set].addr, set, 2'(r[3:2]), 2'b00}, next_rand(),
                      4'((next_rand() % 15) + 1));
          end else begin
            do_miss({16'h0020, 4'h0, set, 4'h0}, 1'b0, '0, '0);
          end
        end
      endcase
      repeat (next_rand() % 4) @(posedge clk);
    end

    while (addr_q.size() != 0 || wdata_q.size() != 0 || phase != 0) @(posedge clk);
    repeat (2) @(posedge clk);
    if (!miss_ready || !uc_ready) begin
      fail_run("DUT did not return to idle after the last operation");
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

// File: flist.f
common/cache_pkg.sv
common/bus_pkg.sv
src/dirty_array.sv
lsu_wport/refill_op_reg.sv
lsu_wport/refill_fsm.sv
lsu_wport/uncached_wbuf.sv
lsu_wport/ram_write_ctrl.sv
lsu_wport/lsu_wport.sv
verif/tb_lsu_wport.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f flist.f --top-module tb_lsu_wport -o tb_lsu_wport
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_lsu_wport > "$log" 2>&1
status=$?
cat "$log"

if grep -q "ERRORS FOUND" "$log"; then
  exit 1
fi

if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

exit 0
